// ==== filelist.f ====
+incdir+include
src/blastn_ext_pkg.sv
src/ext_lane.sv
src/score_tracker.sv
src/ext_control.sv
src/ungapped_ext_top.sv
bench/tb_ungapped_ext.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ungapped extension testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_ungapped_ext \
  --Mdir obj_dir -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -q -F -x "** PASS **"

// ==== include/ext_ref_model.svh ====
// Reference model of the ungapped extension engine
// steps both directions together, one pair each per cycle, with the same
// best tracking and X-drop rule as the hardware

`ifndef EXT_REF_MODEL_SVH
`define EXT_REF_MODEL_SVH

function automatic ext_resp_t ext_ref_model(input ext_req_t req);
  int        hit;
  int        asc_avail;
  int        desc_avail;
  int        asc_n;
  int        desc_n;
  int        idx;
  int        score;
  int        best;
  int        best_asc;
  int        best_desc;
  bit        stopped;
  ext_resp_t resp;

  hit        = int'(req.hit_pos);
  asc_avail  = int'(req.seq_len) - hit;
  desc_avail = hit;
  asc_n      = 0;
  desc_n     = 0;
  score      = 0;
  best       = 0;
  best_asc   = 0;
  best_desc  = 0;
  stopped    = 1'b0;

  while (!stopped && (asc_n < asc_avail || desc_n < desc_avail)) begin
    if (asc_n < asc_avail) begin
      idx = hit + asc_n;
      score += (req.query[2*idx +: 2] == req.database[2*idx +: 2]) ?
               int'(match_score) : int'(mismatch_score);
      asc_n++;
    end
    if (desc_n < desc_avail) begin
      idx = hit - 1 - desc_n;
      score += (req.query[2*idx +: 2] == req.database[2*idx +: 2]) ?
               int'(match_score) : int'(mismatch_score);
      desc_n++;
    end
    // ties move the best forward
    if (score >= best) begin
      best      = score;
      best_asc  = asc_n;
      best_desc = desc_n;
    end
    if (best - score > x_drop) begin
      stopped = 1'b1;
    end
  end

  resp.score   = score_t'(best);
  resp.len     = 8'(best_asc + best_desc);
  resp.q_start = 8'(int'(req.q_start) - best_desc);
  resp.d_start = 8'(int'(req.d_start) - best_desc);
  return resp;
endfunction

`endif

// ==== bench/tb_ungapped_ext.sv ====
// Testbench for the BLASTN ungapped extension engine
// random requests from an xorshift generator, checked against the reference
// model, plus fixed X-drop, back-pressure and edge position cases

`timescale 1ns/10ps

module tb_ungapped_ext
  import blastn_ext_pkg::*;
();

  localparam int random_count  = 200;
  localparam int stall_count   = 30;
  localparam int edge_count    = 10;
  localparam int request_total = 3 + random_count + stall_count + 2 * edge_count;
  localparam int cycle_limit   = 40 * request_total;

  logic        clk;
  logic        reset;
  logic        in_val;
  logic        in_rdy;
  ext_req_t    in_req;
  logic        out_val;
  logic        out_rdy;
  ext_resp_t   out_resp;

  logic [31:0] rng_state;
  int          cycle_count;
  string       test_name;
  int          test_errors;
  int          test_reqs;
  int          tests_run;
  int          tests_failed;
  int          total_errors;
  int          total_reqs;
  int          resp_cycle;
  logic        held;
  ext_resp_t   held_resp;

  `include "ext_ref_model.svh"

  ungapped_ext_top uut (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_req   (in_req),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_resp (out_resp)
  );

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: no progress after %0d cycles", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // response must hold while stalled, and no new request may be taken meanwhile
  always @(negedge clk) begin
    if (!reset) begin
      if (held && out_val && out_resp !== held_resp) begin
        $display("[ERROR] %s out_resp held: expected %h, actual %h",
                 test_name, held_resp, out_resp);
        test_errors++;
      end
      if (out_val && in_rdy) begin
        $display("[ERROR] %s in_rdy while out_val high: expected 0, actual %0d",
                 test_name, in_rdy);
        test_errors++;
      end
      held      = out_val && !out_rdy;
      held_resp = out_resp;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // database mostly close to the query so extensions run a while
  function automatic ext_req_t random_request();
    ext_req_t    r;
    logic [31:0] flips;
    int          len;
    r.query = next_random();
    case (next_random() % 3)
      0: flips = next_random();
      1: flips = next_random() & next_random();
      default: flips = next_random() & next_random() & next_random();
    endcase
    r.database = r.query ^ flips;
    len        = 1 + int'(next_random() % 16);
    r.seq_len  = 16'(len);
    r.hit_pos  = 16'(next_random() % 32'(len));
    r.q_start  = 16'(next_random());
    r.d_start  = 16'(next_random());
    return r;
  endfunction

  task automatic compare_value(input string field, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  task automatic send_request(input ext_req_t req);
    logic accepted;
    accepted = 1'b0;
    in_val   = 1'b1;
    in_req   = req;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_rdy;
      @(posedge clk);
      #1;
    end
    in_val = 1'b0;
  endtask

  // out_rdy stays low for stall cycles once out_val shows up
  // resp_cycle is the cycle after accept in which out_val is first seen
  task automatic take_response(input int stall, output ext_resp_t resp);
    logic got;
    int   left;
    int   cycles;
    got        = 1'b0;
    left       = stall;
    cycles     = 0;
    resp_cycle = 0;
    out_rdy    = (stall == 0);
    while (!got) begin
      @(negedge clk);
      cycles++;
      if (out_val && resp_cycle == 0) begin
        resp_cycle = cycles;
      end
      if (out_val && out_rdy) begin
        resp = out_resp;
        got  = 1'b1;
      end else if (out_val && left > 0) begin
        left--;
      end
      @(posedge clk);
      #1;
      if (!got) begin
        out_rdy = (left == 0);
      end
    end
    out_rdy = 1'b1;
  endtask

  task automatic run_request(input ext_req_t req, input int stall, output ext_resp_t resp);
    send_request(req);
    take_response(stall, resp);
    test_reqs++;
  endtask

  task automatic check_response(input ext_req_t req, input ext_resp_t resp);
    ext_resp_t exp;
    exp = ext_ref_model(req);
    compare_value("score", int'(exp.score), int'(resp.score));
    compare_value("len", int'(exp.len), int'(resp.len));
    compare_value("q_start", int'(exp.q_start), int'(resp.q_start));
    compare_value("d_start", int'(exp.d_start), int'(resp.d_start));
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_reqs   = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_reqs   += test_reqs;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: %0d requests, ok", test_name, test_reqs);
    end else begin
      $display("test %s: %0d requests, %0d errors", test_name, test_reqs, test_errors);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    ext_req_t  r;
    ext_resp_t resp;
    int        stall;

    clk          = 1'b0;
    reset        = 1'b1;
    in_val       = 1'b0;
    in_req       = '0;
    out_rdy      = 1'b1;
    rng_state    = 32'd23372;
    cycle_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_errors = 0;
    total_reqs   = 0;
    resp_cycle   = 0;
    held         = 1'b0;
    held_resp    = '0;

    start_test("reset_identity");
    @(negedge clk);
    compare_value("in_rdy", 0, int'(in_rdy));
    compare_value("out_val", 0, int'(out_val));
    // five reset edges counting the one before this check
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    // in_rdy comes up one edge after reset drops
    @(posedge clk);
    @(negedge clk);
    compare_value("in_rdy", 1, int'(in_rdy));
    compare_value("out_val", 0, int'(out_val));
    @(posedge clk);
    #1;
    r          = random_request();
    r.database = r.query;
    r.hit_pos  = 16'd0;
    r.seq_len  = 16'd16;
    run_request(r, 0, resp);
    compare_value("score", 16, int'(resp.score));
    compare_value("len", 16, int'(resp.len));
    compare_value("q_start", int'(r.q_start[7:0]), int'(resp.q_start));
    compare_value("d_start", int'(r.d_start[7:0]), int'(resp.d_start));
    finish_test();

    start_test("random");
    repeat (random_count) begin
      r = random_request();
      run_request(r, 0, resp);
      check_response(r, resp);
    end
    finish_test();

    start_test("x_drop");
    // every base differs, both lanes drop together
    r          = random_request();
    r.database = ~r.query;
    r.hit_pos  = 16'd8;
    r.seq_len  = 16'd16;
    run_request(r, 0, resp);
    compare_value("score", 0, int'(resp.score));
    compare_value("len", 0, int'(resp.len));
    compare_value("q_start", int'(r.q_start[7:0]), int'(resp.q_start));
    compare_value("d_start", int'(r.d_start[7:0]), int'(resp.d_start));
    check_response(r, resp);
    // -6 per cycle passes the drop limit after 4 compares
    // out_val follows two cycles later instead of after all 8
    compare_value("out_val cycle", 6, resp_cycle);
    // eight matches then mismatches, best stays after base 7
    r          = random_request();
    r.database = r.query ^ 32'hffff_0000;
    r.hit_pos  = 16'd0;
    r.seq_len  = 16'd16;
    run_request(r, 0, resp);
    compare_value("score", 8, int'(resp.score));
    compare_value("len", 8, int'(resp.len));
    compare_value("q_start", int'(r.q_start[7:0]), int'(resp.q_start));
    compare_value("d_start", int'(r.d_start[7:0]), int'(resp.d_start));
    check_response(r, resp);
    // score 8 falls to -13 at compare 15, one short of the full 16
    compare_value("out_val cycle", 17, resp_cycle);
    finish_test();

    start_test("back_pressure");
    repeat (stall_count) begin
      r     = random_request();
      stall = int'(next_random() % 12);
      run_request(r, stall, resp);
      check_response(r, resp);
    end
    finish_test();

    start_test("edge_positions");
    repeat (edge_count) begin
      r         = random_request();
      r.hit_pos = r.seq_len - 16'd1;
      run_request(r, 0, resp);
      check_response(r, resp);
    end
    repeat (edge_count) begin
      r         = random_request();
      r.seq_len = 16'd1;
      r.hit_pos = 16'd0;
      run_request(r, 0, resp);
      check_response(r, resp);
    end
    finish_test();

    $display("tests %0d, failed %0d, requests %0d, errors %0d",
             tests_run, tests_failed, total_reqs, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== src/ungapped_ext_top.sv ====
// BLASTN ungapped extension engine
// one request at a time, extended in both directions from the hit position
// with X-drop termination

`timescale 1ns/10ps

module ungapped_ext_top
  import blastn_ext_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      in_val,
  output logic      in_rdy,
  input  ext_req_t  in_req,
  output logic      out_val,
  input  logic      out_rdy,
  output ext_resp_t out_resp
);

  ext_req_t req;
  logic     load;
  logic     run;
  logic     stopped;
  logic     asc_valid;
  logic     asc_match;
  logic     asc_done;
  logic     desc_valid;
  logic     desc_match;
  logic     desc_done;
  step_t    asc_steps;
  step_t    desc_steps;
  score_t   best_score;
  step_t    best_left;
  step_t    best_right;

  ext_control control (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_req     (in_req),
    .out_val    (out_val),
    .out_rdy    (out_rdy),
    .out_resp   (out_resp),
    .load       (load),
    .run        (run),
    .req        (req),
    .left_done  (asc_done),
    .right_done (desc_done),
    .stopped    (stopped),
    .best_score (best_score),
    .best_left  (best_left),
    .best_right (best_right)
  );

  // hit, hit+1, ... upward
  ext_lane #(.descending(1'b0)) lane_asc (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .req        (req),
    .run        (run),
    .halt       (stopped),
    .step_valid (asc_valid),
    .step_match (asc_match),
    .steps      (asc_steps),
    .done       (asc_done)
  );

  // hit-1, hit-2, ... down to 0
  ext_lane #(.descending(1'b1)) lane_desc (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .req        (req),
    .run        (run),
    .halt       (stopped),
    .step_valid (desc_valid),
    .step_match (desc_match),
    .steps      (desc_steps),
    .done       (desc_done)
  );

  score_tracker tracker (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .left_valid  (asc_valid),
    .left_match  (asc_match),
    .right_valid (desc_valid),
    .right_match (desc_match),
    .left_steps  (asc_steps),
    .right_steps (desc_steps),
    .best_score  (best_score),
    .best_left   (best_left),
    .best_right  (best_right),
    .stopped     (stopped)
  );

endmodule

// ==== src/ext_control.sv ====
// Extension engine control
// valid/ready handshake on both streams, idle/calc/done sequencing, and
// formatting of the response from the tracker's best values

`timescale 1ns/10ps

module ext_control
  import blastn_ext_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      in_val,
  output logic      in_rdy,
  input  ext_req_t  in_req,
  output logic      out_val,
  input  logic      out_rdy,
  output ext_resp_t out_resp,
  output logic      load,
  output logic      run,
  output ext_req_t  req,
  input  logic      left_done,
  input  logic      right_done,
  input  logic      stopped,
  input  score_t    best_score,
  input  step_t     best_left,
  input  step_t     best_right
);

  typedef enum logic [1:0] {
    state_idle,
    state_calc,
    state_done
  } state_t;

  state_t    state;
  state_t    state_next;
  ext_req_t  req_hold;
  ext_resp_t resp_next;
  logic      finish;

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------

  assign load   = in_val & in_rdy;
  assign run    = (state == state_calc);
  assign finish = (left_done & right_done) | stopped;

  always_comb begin
    state_next = state;
    case (state)
      state_idle: begin
        if (load) begin
          state_next = state_calc;
        end
      end
      state_calc: begin
        if (finish) begin
          state_next = state_done;
        end
      end
      state_done: begin
        // hold the response until the consumer takes it
        if (out_rdy) begin
          state_next = state_idle;
        end
      end
      default: state_next = state_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= state_idle;
      in_rdy  <= 1'b0;
      out_val <= 1'b0;
    end else begin
      state   <= state_next;
      in_rdy  <= (state_next == state_idle);
      out_val <= (state_next == state_done);
    end
  end

  // --------------------------------------------------------------------------
  // request hold and response
  // --------------------------------------------------------------------------

  // lanes load straight from the input in the accept cycle
  assign req = in_req;

  // starts move back by the descending steps kept at the best
  always_comb begin
    resp_next.score   = best_score;
    resp_next.len     = 8'(best_left) + 8'(best_right);
    resp_next.q_start = req_hold.q_start[7:0] - 8'(best_right);
    resp_next.d_start = req_hold.d_start[7:0] - 8'(best_right);
  end

  always_ff @(posedge clk) begin
    if (load) begin
      req_hold <= in_req;
    end
    if (run && finish) begin
      out_resp <= resp_next;
    end
  end

endmodule

// ==== src/score_tracker.sv ====
// Extension score tracker
// sums both lanes' pair scores each cycle, keeps the best score and the lane
// step counts where it was reached, and raises stopped on an X-drop

`timescale 1ns/10ps

module score_tracker
  import blastn_ext_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   load,
  input  logic   left_valid,
  input  logic   left_match,
  input  logic   right_valid,
  input  logic   right_match,
  input  step_t  left_steps,
  input  step_t  right_steps,
  output score_t best_score,
  output step_t  best_left,
  output step_t  best_right,
  output logic   stopped
);

  score_t             score;
  score_t             left_pts;
  score_t             right_pts;
  score_t             next_score;
  score_t             next_best;
  logic               new_best;
  logic               any_step;
  logic signed [8:0]  gap;

  // --------------------------------------------------------------------------
  // per cycle update
  // --------------------------------------------------------------------------

  always_comb begin
    left_pts  = '0;
    right_pts = '0;
    if (left_valid) begin
      left_pts = left_match ? match_score : mismatch_score;
    end
    if (right_valid) begin
      right_pts = right_match ? match_score : mismatch_score;
    end
  end

  assign next_score = score + left_pts + right_pts;
  assign any_step   = (left_valid | right_valid) & ~stopped;

  // a tie moves the best forward to the longer extension
  assign new_best  = (next_score >= best_score);
  assign next_best = new_best ? next_score : best_score;

  // one extra bit so the difference cannot wrap
  assign gap = {next_best[7], next_best} - {next_score[7], next_score};

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset || load) begin
      score      <= '0;
      best_score <= '0;
      best_left  <= '0;
      best_right <= '0;
      stopped    <= 1'b0;
    end else if (any_step) begin
      score <= next_score;
      if (new_best) begin
        best_score <= next_score;
        best_left  <= left_steps;
        best_right <= right_steps;
      end
      // X-drop, lanes see this as halt from the next cycle
      if (gap > x_drop) begin
        stopped <= 1'b1;
      end
    end
  end

endmodule

// ==== src/ext_lane.sv ====
// One direction of ungapped extension
// aligns the query and database words on load, then compares one base pair
// per active cycle and flags done when the lane runs out of bases

`timescale 1ns/10ps

module ext_lane
  import blastn_ext_pkg::*;
#(
  parameter bit descending = 1'b0
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     load,
  input  ext_req_t req,
  input  logic     run,
  input  logic     halt,
  output logic     step_valid,
  output logic     step_match,
  output step_t    steps,
  output logic     done
);

  logic [word_bits-1:0] q_word;
  logic [word_bits-1:0] d_word;
  logic [base_bits-1:0] q_base;
  logic [base_bits-1:0] d_base;
  logic [5:0]           shift_bits;
  step_t                avail;
  step_t                avail_load;
  step_t                count;
  logic                 active;

  // alignment for the first compare and number of bases on this side
  always_comb begin
    if (descending) begin
      // base hit-1 has to land in the top slot
      avail_load = step_t'(req.hit_pos);
      shift_bits = 6'((seq_bases - int'(req.hit_pos)) * base_bits);
    end else begin
      avail_load = step_t'(req.seq_len - req.hit_pos);
      shift_bits = 6'(int'(req.hit_pos) * base_bits);
    end
  end

  // compare end of each word
  assign q_base = descending ? q_word[word_bits-1 -: base_bits] : q_word[base_bits-1:0];
  assign d_base = descending ? d_word[word_bits-1 -: base_bits] : d_word[base_bits-1:0];

  assign active     = run & ~halt & ~done;
  assign step_valid = active;
  assign step_match = (q_base == d_base);
  assign steps      = count + step_t'(active);

  // sequence words and lane length
  always_ff @(posedge clk) begin
    if (load) begin
      avail <= avail_load;
      if (descending) begin
        q_word <= req.query << shift_bits;
        d_word <= req.database << shift_bits;
      end else begin
        q_word <= req.query >> shift_bits;
        d_word <= req.database >> shift_bits;
      end
    end else if (active) begin
      // next pair moves into the compare slot
      if (descending) begin
        q_word <= q_word << base_bits;
        d_word <= d_word << base_bits;
      end else begin
        q_word <= q_word >> base_bits;
        d_word <= d_word >> base_bits;
      end
    end
  end

  // step count and end detection
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      done  <= 1'b0;
    end else if (load) begin
      count <= '0;
      done  <= (avail_load == '0);
    end else if (active) begin
      count <= steps;
      if (steps == avail) begin
        done <= 1'b1;
      end
    end
  end

endmodule

// ==== src/blastn_ext_pkg.sv ====
// BLASTN ungapped extension shared definitions
// scoring constants plus the request and response words of the engine

package blastn_ext_pkg;

  // --------------------------------------------------------------------------
  // sequence geometry
  // --------------------------------------------------------------------------

  // two bits per nucleotide, sixteen nucleotides per word
  localparam int base_bits = 2;
  localparam int seq_bases = 16;
  localparam int word_bits = base_bits * seq_bases;

  // --------------------------------------------------------------------------
  // scoring
  // --------------------------------------------------------------------------

  // extension gives up once best minus running score goes past this
  localparam int x_drop = 20;

  // signed score, 32 pairs at most so 8 bits is plenty
  typedef logic signed [7:0] score_t;

  localparam score_t match_score    = 8'sd1;
  localparam score_t mismatch_score = -8'sd3;

  // per lane step count, 0 to 16
  typedef logic [4:0] step_t;

  // --------------------------------------------------------------------------
  // stream words
  // --------------------------------------------------------------------------

  // request, four 32 bit words
  // query in the low word, lengths and positions in the top word
  // base i sits in bits 2i+1..2i of query and database
  typedef struct packed {
    logic [15:0]          seq_len;
    logic [15:0]          hit_pos;
    logic [15:0]          d_start;
    logic [15:0]          q_start;
    logic [word_bits-1:0] database;
    logic [word_bits-1:0] query;
  } ext_req_t;

  // response, one 32 bit word, score in the low byte
  typedef struct packed {
    logic [7:0] d_start;
    logic [7:0] q_start;
    logic [7:0] len;
    score_t     score;
  } ext_resp_t;

endpackage
